//--- icache_defs.svh
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// Geometry of the instruction cache tag side

// Ways per set
`define ICACHE_N_WAY 4

// Sets in the tag array
`define ICACHE_DEPTH 64

// Set index bits, log2 of the depth
`define ICACHE_IDX_W 6

// Tag bits kept per way
`define ICACHE_TAG_W 20

// One SRAM row holds the tags of every way in a set
`define ICACHE_ROW_W (`ICACHE_N_WAY * `ICACHE_TAG_W)

`endif

//--- icache_tag_input.txt
// Columns, all hex: op idx tag exp_hit exp_way exp_victim
// op 0 idle, 1 lookup, 2 refill, 3 flush, f end of data
1 05 aaaaa 0 0 0  // Empty after reset
1 3f 12345 0 0 0
2 05 aaaaa 0 0 0  // First refill lands in way 0
1 05 aaaaa 1 0 0
2 05 bbbbb 0 0 1
2 05 ccccc 0 0 2
2 05 ddddd 0 0 3
1 05 aaaaa 1 0 0  // Back-to-back lookups over all ways
1 05 bbbbb 1 1 0
1 05 ccccc 1 2 0
1 05 ddddd 1 3 0
2 05 eeeee 0 0 0  // Pointer wrapped, way 0 replaced
1 05 aaaaa 0 0 0
1 05 eeeee 1 0 0
1 05 bbbbb 1 1 0
1 05 ccccc 1 2 0
1 05 ddddd 1 3 0
2 2a 0f00d 0 0 1
1 2a 0f00d 1 1 0
1 2a aaaaa 0 0 0
0 00 00000 0 0 0
1 05 ddddd 1 3 0
3 00 00000 0 0 0  // Flush all sets
1 05 eeeee 0 0 0
1 05 bbbbb 0 0 0
1 2a 0f00d 0 0 0
2 2a 0f00d 0 0 2  // Pointer kept across the flush
1 2a 0f00d 1 2 0
0 00 00000 0 0 0
0 00 00000 0 0 0
f 00 00000 0 0 0

//--- icache_tag_pkg.sv
`include "icache_defs.svh"

package icache_tag_pkg;

    // Stored tag of one way
    typedef logic [`ICACHE_TAG_W-1:0] tag_t;

    // Set index into the tag array
    typedef logic [`ICACHE_IDX_W-1:0] index_t;

    // One bit per way, request or valid
    typedef logic [`ICACHE_N_WAY-1:0] way_mask_t;

    // Encoded way number
    typedef logic [$clog2(`ICACHE_N_WAY)-1:0] way_num_t;

    // All tags of a set, way 0 in the low slice
    typedef logic [`ICACHE_N_WAY-1:0][`ICACHE_TAG_W-1:0] way_tags_t;

endpackage

//--- icache_tag_tb.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_tag_tb;

    localparam int    MAX_LINES = 256;                  // Room in the stimulus memory
    localparam int    N_COLS    = 6;                    // Words per data line
    localparam string STIM_FILE = "icache_tag_input.txt";

    localparam logic [`ICACHE_TAG_W-1:0] OP_IDLE   = 'h0;
    localparam logic [`ICACHE_TAG_W-1:0] OP_LOOKUP = 'h1;
    localparam logic [`ICACHE_TAG_W-1:0] OP_REFILL = 'h2;
    localparam logic [`ICACHE_TAG_W-1:0] OP_FLUSH  = 'h3;
    localparam logic [`ICACHE_TAG_W-1:0] OP_END    = 'hf;

    logic                     clk_i;
    logic                     rst_n_i;
    logic                     lookup_i;
    icache_tag_pkg::index_t   lookup_idx_i;
    icache_tag_pkg::tag_t     lookup_tag_i;
    logic                     refill_i;
    icache_tag_pkg::index_t   refill_idx_i;
    icache_tag_pkg::tag_t     refill_tag_i;
    logic                     flush_i;
    logic                     hit_valid_o;
    logic                     hit_o;
    icache_tag_pkg::way_num_t hit_way_o;
    icache_tag_pkg::way_num_t victim_way_o;

    logic [`ICACHE_TAG_W-1:0] stim_mem [MAX_LINES*N_COLS]; // Whole data file as one flat array
    int n_lines;                                        // Operations before the end marker
    int cycle_cnt;                                      // Rising edges since start
    int cycle_limit;                                    // Watchdog limit that stays 0 until loaded
    int err_cnt;
    int n_checked;                                      // Lookup results compared
    int seed;
    int exp_hit_q [$];                                  // Pending lookup expectations
    int exp_way_q [$];
    int due_q [$];                                      // Cycle the result must show up
    int op_num_q [$];

    icache_tag_top i_dut (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .lookup_i     (lookup_i),
        .lookup_idx_i (lookup_idx_i),
        .lookup_tag_i (lookup_tag_i),
        .refill_i     (refill_i),
        .refill_idx_i (refill_idx_i),
        .refill_tag_i (refill_tag_i),
        .flush_i      (flush_i),
        .hit_valid_o  (hit_valid_o),
        .hit_o        (hit_o),
        .hit_way_o    (hit_way_o),
        .victim_way_o (victim_way_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;                     // 40 ns period
    end

    // Cycle count and watchdog
    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Lookups checked: %0d, errors: %0d", n_checked, err_cnt);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Position of the end marker or -1 when the file has none
    function automatic int count_lines();
        for (int k = 0; k < MAX_LINES; k++) begin
            if (stim_mem[k*N_COLS] == OP_END) begin
                return k;
            end
        end
        return -1;
    endfunction

    task automatic apply_op(input int k);
        logic [`ICACHE_TAG_W-1:0] op;
        logic [`ICACHE_TAG_W-1:0] idx;
        logic [`ICACHE_TAG_W-1:0] tag;
        logic [`ICACHE_TAG_W-1:0] e_hit;
        logic [`ICACHE_TAG_W-1:0] e_way;
        logic [`ICACHE_TAG_W-1:0] e_vic;
        op    = stim_mem[k*N_COLS];
        idx   = stim_mem[k*N_COLS+1];
        tag   = stim_mem[k*N_COLS+2];
        e_hit = stim_mem[k*N_COLS+3];
        e_way = stim_mem[k*N_COLS+4];
        e_vic = stim_mem[k*N_COLS+5];
        lookup_i = 1'b0;
        refill_i = 1'b0;
        flush_i  = 1'b0;
        if (op == OP_LOOKUP) begin
            lookup_i     = 1'b1;
            lookup_idx_i = icache_tag_pkg::index_t'(idx);
            lookup_tag_i = icache_tag_pkg::tag_t'(tag);
            exp_hit_q.push_back(int'(e_hit[0]));
            exp_way_q.push_back(int'(e_way[1:0]));
            due_q.push_back(cycle_cnt + 2);             // Sampled next edge and result one later
            op_num_q.push_back(k);
        end else if (op == OP_REFILL) begin
            if (victim_way_o !== e_vic[1:0]) begin
                err_cnt++;
                $display("Mismatch at %0t ns: victim_way_o is %0d, expected %0d (op %0d)",
                         $time, victim_way_o, e_vic[1:0], k);
            end
            refill_i     = 1'b1;
            refill_idx_i = icache_tag_pkg::index_t'(idx);
            refill_tag_i = icache_tag_pkg::tag_t'(tag);
        end else if (op == OP_FLUSH) begin
            flush_i = 1'b1;
        end else if (op == OP_IDLE) begin
            lookup_idx_i = icache_tag_pkg::index_t'($random(seed)); // Noise on idle buses
            lookup_tag_i = icache_tag_pkg::tag_t'($random(seed));
            refill_idx_i = icache_tag_pkg::index_t'($random(seed));
            refill_tag_i = icache_tag_pkg::tag_t'($random(seed));
        end else begin
            err_cnt++;
            $display("Error: data file op %0d has unknown operation code %0h", k, op);
        end
    endtask

    task automatic check_lookup_result();
        int e_hit;
        int e_way;
        int due;
        int op_num;
        e_hit  = exp_hit_q.pop_front();
        e_way  = exp_way_q.pop_front();
        due    = due_q.pop_front();
        op_num = op_num_q.pop_front();
        n_checked++;
        if (cycle_cnt != due) begin
            err_cnt++;
            $display("Error at %0t ns: result of op %0d came in cycle %0d instead of cycle %0d",
                     $time, op_num, cycle_cnt, due);
        end
        if (hit_o !== e_hit[0]) begin
            err_cnt++;
            $display("Mismatch at %0t ns: hit_o is %0b, expected %0b (op %0d)",
                     $time, hit_o, e_hit[0], op_num);
        end
        if (e_hit != 0 && hit_way_o !== e_way[1:0]) begin  // Way only means something on a hit
            err_cnt++;
            $display("Mismatch at %0t ns: hit_way_o is %0d, expected %0d (op %0d)",
                     $time, hit_way_o, e_way[1:0], op_num);
        end
    endtask

    // Results sampled mid cycle
    always @(negedge clk_i) begin
        if (rst_n_i && hit_valid_o) begin
            if (exp_hit_q.size() == 0) begin
                err_cnt++;
                $display("Error at %0t ns: hit_valid_o pulsed with no lookup pending", $time);
            end else begin
                check_lookup_result();
            end
        end
    end

    initial begin
        $timeformat(-9, 0, "", 0);                      // Times in whole ns
        seed         = 32'h2e2e_1904;
        err_cnt      = 0;
        n_checked    = 0;
        cycle_cnt    = 0;
        cycle_limit  = 0;
        rst_n_i      = 1'b0;
        lookup_i     = 1'b0;
        lookup_idx_i = '0;
        lookup_tag_i = '0;
        refill_i     = 1'b0;
        refill_idx_i = '0;
        refill_tag_i = '0;
        flush_i      = 1'b0;
        $readmemh(STIM_FILE, stim_mem);
        n_lines = count_lines();
        if (n_lines <= 0) begin
            err_cnt++;
            $display("Error: data file %s holds no operations or no end marker", STIM_FILE);
            n_lines = 0;
        end
        cycle_limit = 4 * n_lines + 50;
        repeat (10) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;
        if (hit_valid_o !== 1'b0) begin
            err_cnt++;
            $display("Mismatch at %0t ns: hit_valid_o is %0b, expected 0", $time, hit_valid_o);
        end
        if (hit_o !== 1'b0) begin
            err_cnt++;
            $display("Mismatch at %0t ns: hit_o is %0b, expected 0", $time, hit_o);
        end
        for (int k = 0; k < n_lines; k++) begin
            @(posedge clk_i);
            #2;
            apply_op(k);
        end
        @(posedge clk_i);
        #2;
        lookup_i = 1'b0;
        refill_i = 1'b0;
        flush_i  = 1'b0;
        while (exp_hit_q.size() != 0) begin
            @(posedge clk_i);                           // Watchdog catches a lost result
        end
        repeat (2) @(posedge clk_i);                    // Catch stray result pulses
        if (n_checked == 0) begin
            err_cnt++;
            $display("Error: no lookup result was checked");
        end
        $display("Lookups checked: %0d, errors: %0d", n_checked, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- icache_tag_top.sv
`timescale 1ns/1ps

module icache_tag_top (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     lookup_i,
    input  icache_tag_pkg::index_t   lookup_idx_i,
    input  icache_tag_pkg::tag_t     lookup_tag_i,
    input  logic                     refill_i,
    input  icache_tag_pkg::index_t   refill_idx_i,
    input  icache_tag_pkg::tag_t     refill_tag_i,
    input  logic                     flush_i,       // Invalidate the whole cache
    output logic                     hit_valid_o,
    output logic                     hit_o,
    output icache_tag_pkg::way_num_t hit_way_o,
    output icache_tag_pkg::way_num_t victim_way_o
);

    icache_tag_pkg::way_mask_t req;                 // Controller to memory
    logic                      we;
    logic                      vbit;
    icache_tag_pkg::index_t    addr;
    icache_tag_pkg::tag_t      wdata;
    icache_tag_pkg::way_tags_t tag_way;             // Memory back to controller
    icache_tag_pkg::way_mask_t vbit_way;

    itag_ctrl i_itag_ctrl (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .lookup_i     (lookup_i),
        .lookup_idx_i (lookup_idx_i),
        .lookup_tag_i (lookup_tag_i),
        .refill_i     (refill_i),
        .refill_idx_i (refill_idx_i),
        .refill_tag_i (refill_tag_i),
        .tag_way_i    (tag_way),
        .vbit_way_i   (vbit_way),
        .req_o        (req),
        .we_o         (we),
        .vbit_o       (vbit),
        .addr_o       (addr),
        .wdata_o      (wdata),
        .hit_valid_o  (hit_valid_o),
        .hit_o        (hit_o),
        .hit_way_o    (hit_way_o),
        .victim_way_o (victim_way_o)
    );

    itag_memory i_itag_memory (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .req_i      (req),
        .we_i       (we),
        .vbit_i     (vbit),
        .flush_i    (flush_i),                      // Straight from outside
        .data_i     (wdata),
        .addr_i     (addr),
        .tag_way_o  (tag_way),
        .vbit_way_o (vbit_way)
    );

endmodule

//--- itag_ctrl.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module itag_ctrl (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      lookup_i,      // Lookup strobe
    input  icache_tag_pkg::index_t    lookup_idx_i,
    input  icache_tag_pkg::tag_t      lookup_tag_i,
    input  logic                      refill_i,      // Refill strobe
    input  icache_tag_pkg::index_t    refill_idx_i,
    input  icache_tag_pkg::tag_t      refill_tag_i,
    input  icache_tag_pkg::way_tags_t tag_way_i,     // Tags from the memory
    input  icache_tag_pkg::way_mask_t vbit_way_i,    // Valid bits from the memory
    output icache_tag_pkg::way_mask_t req_o,         // Ways to access
    output logic                      we_o,
    output logic                      vbit_o,
    output icache_tag_pkg::index_t    addr_o,
    output icache_tag_pkg::tag_t      wdata_o,
    output logic                      hit_valid_o,   // Lookup result strobe
    output logic                      hit_o,
    output icache_tag_pkg::way_num_t  hit_way_o,
    output icache_tag_pkg::way_num_t  victim_way_o   // Way the next refill writes
);

    icache_tag_pkg::way_num_t  victim_q;             // Round-robin pointer
    icache_tag_pkg::way_mask_t victim_mask;          // One-hot of the pointer
    logic                      lookup_q;             // Lookup in flight
    icache_tag_pkg::tag_t      lookup_tag_q;         // Tag to compare next cycle
    icache_tag_pkg::way_mask_t way_hit;              // Per way match
    icache_tag_pkg::way_num_t  hit_way_enc;          // Encoded matching way

    assign victim_mask = icache_tag_pkg::way_mask_t'(1) << victim_q;

    // Request steering, refill and lookup never overlap
    always_comb begin
        if (refill_i) begin
            req_o = victim_mask;                     // Only the victim slice
        end else if (lookup_i) begin
            req_o = '1;                              // Read all ways
        end else begin
            req_o = '0;
        end
    end

    assign we_o         = refill_i;
    assign vbit_o       = refill_i;                  // Refilled line becomes valid
    assign addr_o       = refill_i ? refill_idx_i : lookup_idx_i;
    assign wdata_o      = refill_tag_i;
    assign victim_way_o = victim_q;

    // Victim pointer, wraps, untouched by flush
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            victim_q <= '0;
        end else if (refill_i) begin
            victim_q <= victim_q + 1'b1;
        end
    end

    // First stage, memory read is under way
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            lookup_q <= 1'b0;
        end else begin
            lookup_q <= lookup_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (lookup_i) begin
            lookup_tag_q <= lookup_tag_i;            // Held for the compare
        end
    end

    // Tag compare, gated by valid
    always_comb begin
        hit_way_enc = '0;
        for (int w = 0; w < `ICACHE_N_WAY; w++) begin
            way_hit[w] = vbit_way_i[w] && (tag_way_i[w] == lookup_tag_q);
            if (way_hit[w]) begin
                hit_way_enc = icache_tag_pkg::way_num_t'(w);
            end
        end
    end

    // Second stage, result registered
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            hit_valid_o <= 1'b0;
            hit_o       <= 1'b0;
        end else begin
            hit_valid_o <= lookup_q;                 // One pulse per lookup
            hit_o       <= lookup_q && (|way_hit);
        end
    end

    always_ff @(posedge clk_i) begin
        if (lookup_q) begin
            hit_way_o <= hit_way_enc;
        end
    end

    // Lookup and refill share the single SRAM port
    a_no_collision : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !(lookup_i && refill_i)
    ) else $error("itag_ctrl: lookup and refill in the same cycle");

    // Refills never duplicate a tag within a set
    a_single_hit : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        lookup_q |-> $onehot0(way_hit)
    ) else $error("itag_ctrl: more than one way hit");

endmodule

//--- itag_memory.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module itag_memory (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  icache_tag_pkg::way_mask_t req_i,       // Ways taking part in the access
    input  logic                     we_i,         // Write when high, else read
    input  logic                     vbit_i,       // Valid bit to store on write
    input  logic                     flush_i,      // Clear every valid bit
    input  icache_tag_pkg::tag_t     data_i,       // Tag to store
    input  icache_tag_pkg::index_t   addr_i,       // Set index
    output icache_tag_pkg::way_tags_t tag_way_o,   // Tags of the read set
    output icache_tag_pkg::way_mask_t vbit_way_o   // Valid bits of the read set
);

    logic [`ICACHE_DEPTH-1:0] vbit_vec_q [`ICACHE_N_WAY]; // Valid flops per way

    logic                     sram_cen;            // Active low
    logic                     sram_wen;            // Active low
    logic [`ICACHE_ROW_W-1:0] sram_bwen;           // Active low per bit
    logic [`ICACHE_ROW_W-1:0] sram_wdata;
    logic [`ICACHE_ROW_W-1:0] sram_q;

    for (genvar w = 0; w < `ICACHE_N_WAY; w++) begin : g_way
        // Valid vector, flush wins over a write in the same cycle
        always_ff @(posedge clk_i) begin
            if (!rst_n_i || flush_i) begin
                vbit_vec_q[w] <= '0;
            end else if (req_i[w] && we_i) begin
                vbit_vec_q[w][addr_i] <= vbit_i;   // Refill marks the way
            end
        end

        // Read copy kept apart so a flush lookup sees old state
        always_ff @(posedge clk_i) begin
            if (!rst_n_i) begin
                vbit_way_o[w] <= 1'b0;
            end else if (req_i[w] && !we_i) begin
                vbit_way_o[w] <= vbit_vec_q[w][addr_i];
            end
        end

        // Way mask widened to a full tag slice
        assign sram_bwen[w*`ICACHE_TAG_W +: `ICACHE_TAG_W] =
            ~{`ICACHE_TAG_W{we_i & req_i[w]}};
        assign sram_wdata[w*`ICACHE_TAG_W +: `ICACHE_TAG_W] = data_i; // Same tag in each slot
        assign tag_way_o[w] = sram_q[w*`ICACHE_TAG_W +: `ICACHE_TAG_W]; // Back to per way
    end

    assign sram_cen = ~(|req_i);                   // Idle when no way requested
    assign sram_wen = ~we_i;

    sram_1p_masked #(
        .WIDTH (`ICACHE_ROW_W),
        .DEPTH (`ICACHE_DEPTH)
    ) i_tag_sram (
        .clk_i  (clk_i),
        .cen_i  (sram_cen),
        .wen_i  (sram_wen),
        .bwen_i (sram_bwen),
        .addr_i (addr_i),
        .d_i    (sram_wdata),
        .q_o    (sram_q)
    );

    // A refill must touch exactly one way
    a_write_onehot : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        we_i |-> $onehot(req_i)
    ) else $error("itag_memory: write request is not one-hot");

endmodule

//--- run_sim.sh
#!/bin/sh
# Compile and run the tag side testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --assert -Wno-fatal -f src.f --top-module icache_tag_tb \
    -o icache_tag_sim > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/icache_tag_sim > sim.log 2>&1 || echo "Simulator returned an error status"

grep -q "^TEST PASSED$" sim.log && echo "Simulation passed" && exit 0 \
    || { echo "Simulation failed, see sim.log"; exit 1; }

//--- sram_1p_masked.sv
`timescale 1ns/1ps

module sram_1p_masked #(
    parameter int WIDTH = 80,                      // Row width in bits
    parameter int DEPTH = 64                       // Number of rows
) (
    input  logic                     clk_i,
    input  logic                     cen_i,        // Chip enable, active low
    input  logic                     wen_i,        // Write enable, active low
    input  logic [WIDTH-1:0]         bwen_i,       // Bit write enable, active low
    input  logic [$clog2(DEPTH)-1:0] addr_i,
    input  logic [WIDTH-1:0]         d_i,
    output logic [WIDTH-1:0]         q_o           // Read row, one cycle later
);

    logic [WIDTH-1:0] mem_q [DEPTH];               // Storage array, powers up unknown

    // Write port, only bits with a low mask bit change
    always_ff @(posedge clk_i) begin
        if (!cen_i && !wen_i) begin
            for (int b = 0; b < WIDTH; b++) begin
                if (!bwen_i[b]) begin
                    mem_q[addr_i][b] <= d_i[b];    // Unmasked bit takes new data
                end
            end
        end
    end

    // Read port, output holds between reads
    always_ff @(posedge clk_i) begin
        if (!cen_i && wen_i) begin
            q_o <= mem_q[addr_i];                  // Registered read data
        end
    end

endmodule

//--- src.f
+incdir+.
icache_tag_pkg.sv
sram_1p_masked.sv
itag_memory.sv
itag_ctrl.sv
icache_tag_top.sv
icache_tag_tb.sv
